// File: Makefile
# Verilator build and run for the credit-based FIFO testbench

VERILATOR ?= verilator
TOP       ?= tb_cfifo
BUILD_DIR ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass is decided by the pass line in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
verilog/cfifo_pkg.sv
verilog/cfifo_if.sv
verilog/cfifo_credit_regs.sv
verilog/cfifo_credit_receiver.sv
verilog/cfifo_push_ctrl.sv
verilog/cfifo_pop_ctrl.sv
verilog/cfifo_ram.sv
verilog/cfifo_top.sv
testbench/tb_cfifo.sv

// File: testbench/tb_cfifo.sv
/*
 * Directed testbench for the credit-based FIFO: sender credit model,
 * reference queue, LCG data, typed compare tasks and five test tasks
 */

`default_nettype none

module tb_cfifo;
  timeunit 1ns;
  timeprecision 100ps;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 push_credit_stall;
  logic                 push_credit;
  logic                 push_valid;
  cfifo_pkg::data_t     push_data;
  logic                 pop;
  logic                 pop_valid;
  cfifo_pkg::data_t     pop_data;
  logic                 cfg_valid;
  cfifo_pkg::cfg_op_e   cfg_op;
  cfifo_pkg::credit_t   cfg_data;
  logic                 full;
  cfifo_pkg::count_t    slots;
  cfifo_pkg::credit_t   credit_count;
  cfifo_pkg::credit_t   credit_available;

  // Sender model and reference state
  cfifo_pkg::data_t     ref_q[$];
  int                   sender_credits;
  int                   pulses;
  logic [31:0]          rand_state;

  cfifo_top DUT (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .pop               (pop),
    .pop_valid         (pop_valid),
    .pop_data          (pop_data),
    .cfg_valid         (cfg_valid),
    .cfg_op            (cfg_op),
    .cfg_data          (cfg_data),
    .full              (full),
    .slots             (slots),
    .credit_count      (credit_count),
    .credit_available  (credit_available)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // ----------------------------------------
  // Error reporting and compares
  // ----------------------------------------
  task automatic stop_on_error();
    $display("Result: FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    stop_on_error();
  endtask

  task automatic check_data(input string name, input cfifo_pkg::data_t got,
                            input cfifo_pkg::data_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input cfifo_pkg::count_t got,
                             input cfifo_pkg::count_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_credit(input string name, input cfifo_pkg::credit_t got,
                              input cfifo_pkg::credit_t exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // Totals kept by the sender model
  task automatic check_total(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // ----------------------------------------
  // Stimulus helpers
  // ----------------------------------------
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Samples after the edge, then clears strobes for the next edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    if (push_credit) begin
      sender_credits++;
      pulses++;
    end
    push_valid = 1'b0;
    pop        = 1'b0;
    cfg_valid  = 1'b0;
    cfg_op     = cfifo_pkg::CFG_NOP;
  endtask

  // Spends one credit
  task automatic push_word();
    logic [31:0] r;
    r = next_rand();
    push_valid = 1'b1;
    push_data  = r[31:16];
    ref_q.push_back(r[31:16]);
    sender_credits--;
  endtask

  // Oldest word must be on pop_data
  task automatic pop_word();
    check_data("pop_data", pop_data, ref_q[0]);
    pop = 1'b1;
    void'(ref_q.pop_front());
  endtask

  // Credits held by DUT, sender and stored words always sum to DEPTH
  task automatic check_conservation();
    check_credit("credit_count", credit_count,
                 cfifo_pkg::credit_t'(cfifo_pkg::DEPTH - sender_credits - ref_q.size()));
  endtask

  // Available credit follows the model's held count, less the withheld amount
  task automatic check_withhold_rule(input int withhold);
    int held;
    int exp;
    held = cfifo_pkg::DEPTH - sender_credits - ref_q.size();
    exp = (held > withhold) ? held - withhold : 0;
    check_credit("credit_available", credit_available, cfifo_pkg::credit_t'(exp));
  endtask

  task automatic wait_sender_credits(input int target, input int limit);
    int i;
    i = 0;
    while (sender_credits != target) begin
      if (i >= limit) report_timeout("sender credits to return");
      next_cycle();
      i++;
    end
  endtask

  task automatic send_and_drain(input int count, input int withhold);
    int pushed;
    int i;
    pushed = 0;
    i = 0;
    while (pushed < count || ref_q.size() > 0) begin
      if (i >= 100) report_timeout("words to pass through");
      if (pop_valid) pop_word();
      if (pushed < count && sender_credits > 0) begin
        push_word();
        pushed++;
      end
      next_cycle();
      i++;
      check_conservation();
      if (withhold > 0) check_withhold_rule(withhold);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic test_reset_credits();
    int i;
    i = 0;
    while (sender_credits < cfifo_pkg::DEPTH) begin
      if (i >= 50) report_timeout("initial credit pulses");
      next_cycle();
      i++;
    end
    // No pulse beyond the initial grant
    repeat (20) next_cycle();
    check_total("initial credit pulses", pulses, cfifo_pkg::DEPTH);
    check_credit("credit_count", credit_count, '0);
    check_count("slots", slots, cfifo_pkg::count_t'(cfifo_pkg::DEPTH));
    check_bit("full", full, 1'b0);
  endtask

  task automatic test_fill_drain();
    int i;
    i = 0;
    while (ref_q.size() < cfifo_pkg::DEPTH) begin
      if (i >= 50) report_timeout("FIFO to fill");
      if (sender_credits > 0) push_word();
      next_cycle();
      i++;
    end
    check_count("slots", slots, '0);
    check_bit("full", full, 1'b1);
    check_bit("pop_valid", pop_valid, 1'b1);
    i = 0;
    while (ref_q.size() > 0) begin
      if (i >= 50) report_timeout("FIFO to drain");
      if (pop_valid) pop_word();
      next_cycle();
      i++;
    end
    check_bit("pop_valid", pop_valid, 1'b0);
    check_count("slots", slots, cfifo_pkg::count_t'(cfifo_pkg::DEPTH));
  endtask

  task automatic test_credit_return();
    int start;
    int pops;
    logic [31:0] r;
    // Drained words from the fill test give every credit back
    wait_sender_credits(cfifo_pkg::DEPTH, 50);
    check_conservation();
    start = pulses;
    pops = 0;
    repeat (100) begin
      r = next_rand();
      if (r[1] && pop_valid) begin
        pop_word();
        pops++;
      end
      if (r[0] && sender_credits > 0) push_word();
      next_cycle();
      check_bit("pop_valid", pop_valid, ref_q.size() != 0);
      check_count("slots", slots, cfifo_pkg::count_t'(cfifo_pkg::DEPTH - ref_q.size()));
      check_conservation();
    end
    pops += ref_q.size();
    send_and_drain(0, 0);
    wait_sender_credits(cfifo_pkg::DEPTH, 50);
    check_total("credit pulses against pops", pulses - start, pops);
  endtask

  task automatic test_stall();
    int start;
    push_credit_stall = 1'b1;
    start = pulses;
    send_and_drain(3, 0);
    repeat (20) next_cycle();
    check_total("credit pulses while stalled", pulses - start, 0);
    check_credit("credit_count", credit_count, cfifo_pkg::credit_t'(3));
    // Held credits come out after release
    push_credit_stall = 1'b0;
    wait_sender_credits(cfifo_pkg::DEPTH, 50);
    check_total("credit pulses after stall", pulses - start, 3);
  endtask

  task automatic test_withhold_reinit();
    cfg_valid = 1'b1;
    cfg_op    = cfifo_pkg::CFG_WITHHOLD;
    cfg_data  = cfifo_pkg::credit_t'(3);
    next_cycle();
    send_and_drain(5, 3);
    // Two of five come back, three stay counted
    wait_sender_credits(cfifo_pkg::DEPTH - 3, 50);
    repeat (20) begin
      next_cycle();
      check_withhold_rule(3);
    end
    check_total("sender credits under withhold", sender_credits, cfifo_pkg::DEPTH - 3);
    check_credit("credit_count", credit_count, cfifo_pkg::credit_t'(3));
    check_credit("credit_available", credit_available, '0);
    cfg_valid = 1'b1;
    cfg_op    = cfifo_pkg::CFG_INITIAL;
    cfg_data  = cfifo_pkg::credit_t'(6);
    next_cycle();
    cfg_valid = 1'b1;
    cfg_op    = cfifo_pkg::CFG_REINIT;
    next_cycle();
    next_cycle();
    check_credit("credit_count", credit_count, cfifo_pkg::credit_t'(6));
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    rst_n             = 1'b0;
    push_credit_stall = 1'b0;
    push_valid        = 1'b0;
    push_data         = '0;
    pop               = 1'b0;
    cfg_valid         = 1'b0;
    cfg_op            = cfifo_pkg::CFG_NOP;
    cfg_data          = '0;
    sender_credits    = 0;
    pulses            = 0;
    rand_state        = 32'hdd5c_9146;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_credits();
    test_fill_drain();
    test_credit_return();
    test_stall();
    test_withhold_reinit();
    $display("Result: PASSED");
    $finish;
  end

  // Backstop in case a loop bound is ever missed
  initial begin
    #200000;
    $display("simulation ran too long at %0t", $time);
    stop_on_error();
  end

endmodule

`default_nettype wire

// File: verilog/cfifo_credit_receiver.sv
/*
 * Credit receiver: credit counter, available credit after withhold,
 * registered credit pulse and forwarding of the push inputs
 */

`default_nettype none

module cfifo_credit_receiver (
  input  wire                     clk,
  input  wire                     rst_n,
  // Sender side
  input  wire                     push_credit_stall,
  output logic                    push_credit,
  input  wire                     push_valid,
  input  wire cfifo_pkg::data_t   push_data,
  // From configuration registers
  input  wire cfifo_pkg::credit_t credit_initial,
  input  wire cfifo_pkg::credit_t credit_withhold,
  input  wire                     reinit,
  // Status
  output cfifo_pkg::credit_t      credit_count,
  output cfifo_pkg::credit_t      credit_available,
  // Internal write toward push controller
  output logic                    wr_valid_int,
  output cfifo_pkg::data_t        wr_data_int,
  cfifo_if.credit                 fifo
);

  logic               credit_grant;
  cfifo_pkg::credit_t credit_count_next;

  // ----------------------------------------
  // Push forwarding
  // ----------------------------------------

  // Sender only pushes against a held credit, so no flow control here
  assign wr_valid_int = push_valid;
  assign wr_data_int  = push_data;

  // ----------------------------------------
  // Credit accounting
  // ----------------------------------------

  // Withheld credits stay counted but are not handed out
  assign credit_available = (credit_count > credit_withhold) ?
                            (credit_count - credit_withhold) : '0;

  // Grant a pulse at this edge; suppressed during a reload
  assign credit_grant = (credit_available != '0) && !push_credit_stall && !reinit;

  // Freed slot adds one, granted pulse removes one
  always_comb begin
    if (reinit) begin
      credit_count_next = credit_initial;
    end else begin
      credit_count_next = credit_count
                        + cfifo_pkg::credit_t'(fifo.pop_beat)
                        - cfifo_pkg::credit_t'(credit_grant);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_count <= cfifo_pkg::credit_t'(cfifo_pkg::DEPTH);
      push_credit  <= 1'b0;
    end else begin
      credit_count <= credit_count_next;
      push_credit  <= credit_grant;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // A pop with the count already at DEPTH means a lost credit somewhere
  credit_count_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    32'(credit_count) <= cfifo_pkg::DEPTH
  ) else $error("credit_count above DEPTH");

endmodule

`default_nettype wire

// File: verilog/cfifo_credit_regs.sv
/*
 * Configuration registers for initial and withheld credit
 * and the credit reinit pulse
 */

`default_nettype none

module cfifo_credit_regs (
  input  wire                     clk,
  input  wire                     rst_n,
  // Configuration strobe
  input  wire                     cfg_valid,
  input  wire cfifo_pkg::cfg_op_e cfg_op,
  input  wire cfifo_pkg::credit_t cfg_data,
  // To credit receiver
  output cfifo_pkg::credit_t      credit_initial,
  output cfifo_pkg::credit_t      credit_withhold,
  output logic                    reinit
);

  // ----------------------------------------
  // Opcode decode
  // ----------------------------------------

  // Registers load at the strobe edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credit_initial  <= cfifo_pkg::credit_t'(cfifo_pkg::DEPTH);
      credit_withhold <= '0;
    end else if (cfg_valid) begin
      case (cfg_op)
        cfifo_pkg::CFG_INITIAL:  credit_initial  <= cfg_data;
        cfifo_pkg::CFG_WITHHOLD: credit_withhold <= cfg_data;
        default: begin
        end
      endcase
    end
  end

  // Reinit is a one-cycle registered pulse
  // Count reloads one edge after it, two after the strobe
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reinit <= 1'b0;
    end else begin
      reinit <= cfg_valid && (cfg_op == cfifo_pkg::CFG_REINIT);
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Initial credit above DEPTH would let the sender overrun storage
  initial_credit_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_valid && (cfg_op == cfifo_pkg::CFG_INITIAL)
      |=> 32'(credit_initial) <= cfifo_pkg::DEPTH
  ) else $error("credit_initial written above DEPTH");

endmodule

`default_nettype wire

// File: verilog/cfifo_if.sv
/*
 * Internal FIFO bus: storage write and read ports
 * plus the push and pop beat pulses between controllers
 */

`default_nettype none

interface cfifo_if;

  // ----------------------------------------
  // Storage write port
  // ----------------------------------------
  logic              wr_valid;
  cfifo_pkg::addr_t  wr_addr;
  cfifo_pkg::data_t  wr_data;

  // Storage read port, combinational read
  cfifo_pkg::addr_t  rd_addr;
  cfifo_pkg::data_t  rd_data;

  // One pulse per accepted word, one per removed word
  logic              push_beat;
  logic              pop_beat;

  // Push side writes storage, watches pops for free slots
  modport push (
    output wr_valid, wr_addr, wr_data, push_beat,
    input  pop_beat
  );

  // Pop side reads storage, watches pushes for occupancy
  modport pop (
    output rd_addr, pop_beat,
    input  rd_data, push_beat
  );

  modport ram (
    input  wr_valid, wr_addr, wr_data, rd_addr,
    output rd_data
  );

  // Credit return only needs to know a slot was freed
  modport credit (
    input pop_beat
  );

endinterface

`default_nettype wire

// File: verilog/cfifo_pkg.sv
/*
 * Shared sizes, word types and the configuration opcode
 * for the credit-based FIFO
 */

`default_nettype none

package cfifo_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Storage slots, also the largest credit count
  localparam int DEPTH = 8;
  // Data word width
  localparam int WIDTH = 16;
  // Pointer width for DEPTH slots
  localparam int ADDR_W = 3;
  // Counts from 0 up to DEPTH inclusive
  localparam int COUNT_W = 4;
  localparam int CREDIT_W = 4;

  // ----------------------------------------
  // Types
  // ----------------------------------------

  typedef logic [WIDTH-1:0] data_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [COUNT_W-1:0] count_t;
  typedef logic [CREDIT_W-1:0] credit_t;

  // Configuration opcodes, decoded on a cfg_valid strobe
  typedef enum logic [1:0] {
    CFG_NOP      = 2'd0,
    CFG_INITIAL  = 2'd1,  // write initial credit
    CFG_WITHHOLD = 2'd2,  // write withheld credit
    CFG_REINIT   = 2'd3   // reload count from initial credit
  } cfg_op_e;

endpackage

`default_nettype wire

// File: verilog/cfifo_pop_ctrl.sv
/*
 * Pop controller: read pointer, occupancy count,
 * registered pop_valid and pop data from storage
 */

`default_nettype none

module cfifo_pop_ctrl (
  input  wire              clk,
  input  wire              rst_n,
  // Receiver side
  input  wire              pop,
  output logic             pop_valid,
  output cfifo_pkg::data_t pop_data,
  cfifo_if.pop             fifo
);

  cfifo_pkg::addr_t  rd_ptr;
  cfifo_pkg::count_t items;
  cfifo_pkg::count_t items_next;

  // ----------------------------------------
  // Read side
  // ----------------------------------------

  // Pop only counts while a word is shown
  assign fifo.pop_beat = pop && pop_valid;
  assign fifo.rd_addr  = rd_ptr;
  // Oldest word straight from the storage read port
  assign pop_data      = fifo.rd_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (fifo.pop_beat) begin
      if (rd_ptr == cfifo_pkg::addr_t'(cfifo_pkg::DEPTH - 1)) begin
        rd_ptr <= '0;
      end else begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------

  // Push raises, pop lowers
  assign items_next = items
                    + cfifo_pkg::count_t'(fifo.push_beat)
                    - cfifo_pkg::count_t'(fifo.pop_beat);

  // pop_valid rises the edge after the first push lands
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      items     <= '0;
      pop_valid <= 1'b0;
    end else begin
      items     <= items_next;
      pop_valid <= (items_next != '0);
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Receiver must wait for pop_valid
  no_underflow_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> pop_valid
  ) else $error("pop without pop_valid");

endmodule

`default_nettype wire

// File: verilog/cfifo_push_ctrl.sv
/*
 * Push controller: write pointer, storage write,
 * free-slot counter and registered full flag
 */

`default_nettype none

module cfifo_push_ctrl (
  input  wire                   clk,
  input  wire                   rst_n,
  // Internal write from credit receiver
  input  wire                   wr_valid_int,
  input  wire cfifo_pkg::data_t wr_data_int,
  // Status
  output logic                  full,
  output cfifo_pkg::count_t     slots,
  cfifo_if.push                 fifo
);

  cfifo_pkg::addr_t  wr_ptr;
  cfifo_pkg::count_t slots_next;

  // ----------------------------------------
  // Storage write
  // ----------------------------------------

  // Every push is accepted, credit already guarantees room
  assign fifo.wr_valid  = wr_valid_int;
  assign fifo.wr_addr   = wr_ptr;
  assign fifo.wr_data   = wr_data_int;
  assign fifo.push_beat = wr_valid_int;

  // Write pointer wraps at DEPTH
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (fifo.push_beat) begin
      if (wr_ptr == cfifo_pkg::addr_t'(cfifo_pkg::DEPTH - 1)) begin
        wr_ptr <= '0;
      end else begin
        wr_ptr <= wr_ptr + 1'b1;
      end
    end
  end

  // ----------------------------------------
  // Free slots and full
  // ----------------------------------------

  // Simultaneous push and pop leave the count unchanged
  assign slots_next = slots
                    - cfifo_pkg::count_t'(fifo.push_beat)
                    + cfifo_pkg::count_t'(fifo.pop_beat);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      slots <= cfifo_pkg::count_t'(cfifo_pkg::DEPTH);
      full  <= 1'b0;
    end else if (fifo.push_beat || fifo.pop_beat) begin
      slots <= slots_next;
      full  <= (slots_next == '0);
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // Sender pushed without a credit
  no_overflow_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_valid_int |-> !full
  ) else $error("push while full");

  slots_in_range_a : assert property (
    @(posedge clk) disable iff (!rst_n)
    32'(slots) <= cfifo_pkg::DEPTH
  ) else $error("slots above DEPTH");

endmodule

`default_nettype wire

// File: verilog/cfifo_ram.sv
/*
 * Flip-flop storage, synchronous write and combinational read
 */

`default_nettype none

module cfifo_ram (
  input  wire  clk,
  cfifo_if.ram fifo
);

  // DEPTH words of WIDTH bits, no reset on payload
  cfifo_pkg::data_t mem [cfifo_pkg::DEPTH];

  always_ff @(posedge clk) begin
    if (fifo.wr_valid) begin
      mem[fifo.wr_addr] <= fifo.wr_data;
    end
  end

  // Read flows through in the same cycle
  assign fifo.rd_data = mem[fifo.rd_addr];

endmodule

`default_nettype wire

// File: verilog/cfifo_top.sv
/*
 * Credit-based FIFO top level, instances and wiring only
 */

`default_nettype none

module cfifo_top (
  input  wire                     clk,
  input  wire                     rst_n,
  // Sender side
  input  wire                     push_credit_stall,
  output logic                    push_credit,
  input  wire                     push_valid,
  input  wire cfifo_pkg::data_t   push_data,
  // Receiver side
  input  wire                     pop,
  output logic                    pop_valid,
  output cfifo_pkg::data_t        pop_data,
  // Configuration
  input  wire                     cfg_valid,
  input  wire cfifo_pkg::cfg_op_e cfg_op,
  input  wire cfifo_pkg::credit_t cfg_data,
  // Status
  output logic                    full,
  output cfifo_pkg::count_t       slots,
  output cfifo_pkg::credit_t      credit_count,
  output cfifo_pkg::credit_t      credit_available
);

  logic               wr_valid_int;
  cfifo_pkg::data_t   wr_data_int;
  cfifo_pkg::credit_t credit_initial;
  cfifo_pkg::credit_t credit_withhold;
  logic               reinit;

  cfifo_if fifo ();

  // ----------------------------------------
  // Credit side
  // ----------------------------------------
  cfifo_credit_regs u_credit_regs (
    .clk             (clk),
    .rst_n           (rst_n),
    .cfg_valid       (cfg_valid),
    .cfg_op          (cfg_op),
    .cfg_data        (cfg_data),
    .credit_initial  (credit_initial),
    .credit_withhold (credit_withhold),
    .reinit          (reinit)
  );

  cfifo_credit_receiver u_credit_receiver (
    .clk               (clk),
    .rst_n             (rst_n),
    .push_credit_stall (push_credit_stall),
    .push_credit       (push_credit),
    .push_valid        (push_valid),
    .push_data         (push_data),
    .credit_initial    (credit_initial),
    .credit_withhold   (credit_withhold),
    .reinit            (reinit),
    .credit_count      (credit_count),
    .credit_available  (credit_available),
    .wr_valid_int      (wr_valid_int),
    .wr_data_int       (wr_data_int),
    .fifo              (fifo)
  );

  // ----------------------------------------
  // Data path
  // ----------------------------------------
  cfifo_push_ctrl u_push_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_valid_int (wr_valid_int),
    .wr_data_int  (wr_data_int),
    .full         (full),
    .slots        (slots),
    .fifo         (fifo)
  );

  cfifo_ram u_ram (
    .clk  (clk),
    .fifo (fifo)
  );

  cfifo_pop_ctrl u_pop_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .pop       (pop),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .fifo      (fifo)
  );

endmodule

`default_nettype wire
